//--- Makefile
# Verilator build and run for the organ testbench

VERILATOR ?= verilator
TOP       ?= organ_tb
FILELIST  ?= organ_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/display_pkg.sv
`default_nettype none

package display_pkg;

  // ======================================================================
  // Seven-segment display
  // ======================================================================

  // Active low, bit order gfedcba
  typedef logic [6:0] seg_t;

  // Indexed by a 4-bit code, 10 to 15 stay dark
  localparam seg_t SEG_DIGIT [16] = '{
    7'b1000000,
    7'b1111001,
    7'b0100100,
    7'b0110000,
    7'b0011001,
    7'b0010010,
    7'b0000010,
    7'b1111000,
    7'b0000000,
    7'b0010000,
    7'b1111111,
    7'b1111111,
    7'b1111111,
    7'b1111111,
    7'b1111111,
    7'b1111111
  };

  // ======================================================================
  // LEDs
  // ======================================================================

  localparam int LED_COUNT = 8;

  typedef logic [LED_COUNT-1:0] led_t;

endpackage

`default_nettype wire

//--- common/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ======================================================================
  // Note table
  // ======================================================================

  localparam int NOTE_COUNT = 8;
  localparam int NOTE_SEL_W = 3;

  // One octave starting at C5, in Hz
  localparam int NOTE_HZ [NOTE_COUNT] = '{
    523,
    587,
    659,
    698,
    783,
    880,
    987,
    1046
  };

  typedef logic [15:0] freq_bcd_t;

  // Same frequencies as four BCD digits for the display
  localparam freq_bcd_t NOTE_BCD [NOTE_COUNT] = '{
    16'h0523,
    16'h0587,
    16'h0659,
    16'h0698,
    16'h0783,
    16'h0880,
    16'h0987,
    16'h1046
  };

  // Wide enough for CLOCK_HZ / (2 * 523) at a 50 MHz clock
  localparam int HALF_PERIOD_W = 24;

  // Registered settings of the selected note
  typedef struct packed {
    logic [HALF_PERIOD_W-1:0] half_period;
    freq_bcd_t                freq_bcd;
    logic                     tone_on;
  } note_info_t;

  // ======================================================================
  // Audio samples
  // ======================================================================

  typedef logic signed [7:0] sample_t;

  localparam sample_t SAMPLE_HIGH = 8'sh0F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;

endpackage

`default_nettype wire

//--- organ_top.f
common/organ_pkg.sv
common/display_pkg.sv
tone/note_table.sv
tone/tone_divider.sv
rtl/sample_stream.sv
rtl/led_sweep.sv
rtl/seg_display.sv
rtl/organ_top.sv
verif/organ_tb_props.sv
verif/organ_tb.sv

//--- rtl/led_sweep.sv
`timescale 1ns/1ps
`default_nettype none

module led_sweep #(
  parameter int SWEEP_PERIOD = 12_500_000
) (
  input  wire               clock,
  input  wire               reset,
  output display_pkg::led_t led
);

  localparam int STEP_W = $clog2(SWEEP_PERIOD);
  localparam int POS_W  = $clog2(display_pkg::LED_COUNT);
  localparam int LAST   = display_pkg::LED_COUNT - 1;

  logic [STEP_W-1:0] step_count;
  logic [POS_W-1:0]  position;
  logic              going_down;
  logic              step;

  assign step = (step_count == STEP_W'(SWEEP_PERIOD - 1));

  always_ff @(posedge clock)
  begin
    if (reset || step)
      step_count <= '0;
    else
      step_count <= step_count + STEP_W'(1);
  end

  // Bounce between the two end LEDs
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      position   <= '0;
      going_down <= 1'b0;
    end
    else if (step)
    begin
      if (going_down)
      begin
        position <= position - POS_W'(1);
        if (position == POS_W'(1))
          going_down <= 1'b0;
      end
      else
      begin
        position <= position + POS_W'(1);
        if (position == POS_W'(LAST - 1))
          going_down <= 1'b1;
      end
    end
  end

  assign led = display_pkg::led_t'(1) << position;

endmodule

`default_nettype wire

//--- rtl/organ_top.sv
`timescale 1ns/1ps
`default_nettype none

module organ_top #(
  parameter int CLOCK_HZ      = 50_000_000,
  parameter int SAMPLE_PERIOD = 6250,
  parameter int SWEEP_PERIOD  = 12_500_000
) (
  input  wire                              clock,
  input  wire                              reset,
  input  wire  [organ_pkg::NOTE_SEL_W-1:0] note_select,
  input  wire                              tone_enable,
  input  wire                              audio_ready,
  output logic                             tone,
  output organ_pkg::sample_t               audio_data,
  output logic                             audio_valid,
  output display_pkg::led_t                led,
  output display_pkg::seg_t                hex0,
  output display_pkg::seg_t                hex1,
  output display_pkg::seg_t                hex2,
  output display_pkg::seg_t                hex3
);

  // Settings of the selected note, shared by tone and display
  organ_pkg::note_info_t note_info;

  // ======================================================================
  // Note selection
  // ======================================================================

  note_table #(
    .CLOCK_HZ (CLOCK_HZ)
  ) note_table_inst (
    .clock       (clock),
    .reset       (reset),
    .note_select (note_select),
    .tone_enable (tone_enable),
    .note        (note_info)
  );

  // ======================================================================
  // Tone and audio samples
  // ======================================================================

  tone_divider tone_divider_inst (
    .clock (clock),
    .reset (reset),
    .note  (note_info),
    .tone  (tone)
  );

  sample_stream #(
    .SAMPLE_PERIOD (SAMPLE_PERIOD)
  ) sample_stream_inst (
    .clock       (clock),
    .reset       (reset),
    .tone        (tone),
    .audio_ready (audio_ready),
    .audio_data  (audio_data),
    .audio_valid (audio_valid)
  );

  // ======================================================================
  // LEDs and frequency readout
  // ======================================================================

  led_sweep #(
    .SWEEP_PERIOD (SWEEP_PERIOD)
  ) led_sweep_inst (
    .clock (clock),
    .reset (reset),
    .led   (led)
  );

  seg_display seg_display_inst (
    .clock (clock),
    .reset (reset),
    .note  (note_info),
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3)
  );

endmodule

`default_nettype wire

//--- rtl/sample_stream.sv
`timescale 1ns/1ps
`default_nettype none

module sample_stream #(
  parameter int SAMPLE_PERIOD = 6250
) (
  input  wire                clock,
  input  wire                reset,
  input  wire                tone,
  input  wire                audio_ready,
  output organ_pkg::sample_t audio_data,
  output logic               audio_valid
);

  localparam int TICK_W = $clog2(SAMPLE_PERIOD);

  logic [TICK_W-1:0] tick_count;
  logic              tick;
  logic              load;

  assign tick = (tick_count == TICK_W'(SAMPLE_PERIOD - 1));

  // Output register is free or draining this cycle
  assign load = tick && (!audio_valid || audio_ready);

  // Sample rate tick
  always_ff @(posedge clock)
  begin
    if (reset)
      tick_count <= '0;
    else if (tick)
      tick_count <= '0;
    else
      tick_count <= tick_count + TICK_W'(1);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      audio_valid <= 1'b0;
    else if (load)
      audio_valid <= 1'b1;
    else if (audio_ready)
      audio_valid <= 1'b0;
  end

  // Payload, a stalled tick is simply lost
  always_ff @(posedge clock)
  begin
    if (load)
      audio_data <= tone ? organ_pkg::SAMPLE_HIGH : organ_pkg::SAMPLE_LOW;
  end

endmodule

`default_nettype wire

//--- rtl/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display (
  input  wire                        clock,
  input  wire                        reset,
  input  wire organ_pkg::note_info_t note,
  output display_pkg::seg_t          hex0,
  output display_pkg::seg_t          hex1,
  output display_pkg::seg_t          hex2,
  output display_pkg::seg_t          hex3
);

  // Index 0 is the least significant digit
  display_pkg::seg_t digit_seg [4];

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (reset)
        digit_seg[i] <= display_pkg::SEG_DIGIT[0];
      else
        digit_seg[i] <= display_pkg::SEG_DIGIT[note.freq_bcd[4*i +: 4]];
    end
  end

  assign hex0 = digit_seg[0];
  assign hex1 = digit_seg[1];
  assign hex2 = digit_seg[2];
  assign hex3 = digit_seg[3];

endmodule

`default_nettype wire

//--- tone/note_table.sv
`timescale 1ns/1ps
`default_nettype none

module note_table #(
  parameter int CLOCK_HZ = 50_000_000
) (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire  [organ_pkg::NOTE_SEL_W-1:0]    note_select,
  input  wire                                 tone_enable,
  output organ_pkg::note_info_t               note
);

  localparam int HPW = organ_pkg::HALF_PERIOD_W;

  logic [organ_pkg::NOTE_SEL_W-1:0] select_meta;
  logic [organ_pkg::NOTE_SEL_W-1:0] select_sync;
  logic                             enable_meta;
  logic                             enable_sync;

  logic [HPW-1:0] half_table [organ_pkg::NOTE_COUNT];

  // Half periods are fixed at elaboration, no divider in hardware
  for (genvar i = 0; i < organ_pkg::NOTE_COUNT; i++)
  begin : g_half
    assign half_table[i] = HPW'(CLOCK_HZ / (2 * organ_pkg::NOTE_HZ[i]));
  end

  // Two-flop synchronizers for the switches
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      select_meta <= '0;
      select_sync <= '0;
      enable_meta <= 1'b0;
      enable_sync <= 1'b0;
    end
    else
    begin
      select_meta <= note_select;
      select_sync <= select_meta;
      enable_meta <= tone_enable;
      enable_sync <= enable_meta;
    end
  end

  // Settings register, third stage after the switches
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      note.half_period <= half_table[0];
      note.freq_bcd    <= organ_pkg::NOTE_BCD[0];
      note.tone_on     <= 1'b0;
    end
    else
    begin
      note.half_period <= half_table[select_sync];
      note.freq_bcd    <= organ_pkg::NOTE_BCD[select_sync];
      note.tone_on     <= enable_sync;
    end
  end

endmodule

`default_nettype wire

//--- tone/tone_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tone_divider (
  input  wire                    clock,
  input  wire                    reset,
  input  wire organ_pkg::note_info_t note,
  output logic                   tone
);

  localparam int HPW = organ_pkg::HALF_PERIOD_W;

  logic [HPW-1:0] count;
  logic [HPW-1:0] last_half;
  logic           half_changed;
  logic           half_done;

  assign half_changed = (note.half_period != last_half);
  assign half_done    = (count == note.half_period - HPW'(1));

  // Remember the half period to catch a note change
  always_ff @(posedge clock)
  begin
    if (reset)
      last_half <= '0;
    else
      last_half <= note.half_period;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      count <= '0;
      tone  <= 1'b0;
    end
    else if (!note.tone_on)
    begin
      // Silent, hold everything at rest
      count <= '0;
      tone  <= 1'b0;
    end
    else if (half_changed)
    begin
      // New note starts its count from zero
      count <= '0;
    end
    else if (half_done)
    begin
      count <= '0;
      tone  <= ~tone;
    end
    else
    begin
      count <= count + HPW'(1);
    end
  end

endmodule

`default_nettype wire

//--- verif/organ_tb.sv
`timescale 1ns/1ps
`default_nettype none

module organ_tb;

  localparam int TB_CLOCK_HZ    = 104_600;
  localparam int DRIVE_DELAY    = 1;
  localparam int RUN_LIMIT      = 1000;
  localparam int TIMEOUT_CYCLES = 20_000;

  logic                             clock;
  logic                             reset;
  logic [organ_pkg::NOTE_SEL_W-1:0] note_select;
  logic                             tone_enable;
  logic                             audio_ready;
  logic                             tone;
  organ_pkg::sample_t               audio_data;
  logic                             audio_valid;
  display_pkg::led_t                led;
  display_pkg::seg_t                hex0;
  display_pkg::seg_t                hex1;
  display_pkg::seg_t                hex2;
  display_pkg::seg_t                hex3;
  int                               error_count;
  int                               cycle_count;
  logic [31:0]                      rng_state;

  // Small periods so every test runs in a few thousand cycles
  organ_top #(
    .CLOCK_HZ      (TB_CLOCK_HZ),
    .SAMPLE_PERIOD (16),
    .SWEEP_PERIOD  (8)
  ) organ_top_inst (.*);

  bind organ_top organ_tb_props organ_tb_props_inst (
    .clock       (clock),
    .reset       (reset),
    .audio_valid (audio_valid),
    .audio_ready (audio_ready),
    .audio_data  (audio_data),
    .led         (led)
  );

  always #50 clock = ~clock;

  // ======================================================================
  // Helpers
  // ======================================================================

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (4) next_cycle();
    reset = 1'b0;
  endtask

  task automatic log_failure(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %0d errors", name, error_count - errors_before);
  endtask

  // Cycles until the tone level next changes
  task automatic measure_run(output int cycles, output bit toggled);
    logic start;
    start = tone;
    cycles = 0;
    toggled = 1'b0;
    while (!toggled && cycles < RUN_LIMIT)
    begin
      next_cycle();
      cycles++;
      toggled = (tone != start);
    end
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================

  task automatic check_tone_periods();
    int errors_before;
    int expected;
    int cycles;
    bit toggled;
    errors_before = error_count;
    tone_enable = 1'b1;
    audio_ready = 1'b1;
    for (int i = 0; i < organ_pkg::NOTE_COUNT; i++)
    begin
      note_select = 3'(i);
      expected = TB_CLOCK_HZ / (2 * organ_pkg::NOTE_HZ[i]);
      repeat (6) next_cycle();
      // Run spanning the note change is skipped
      measure_run(cycles, toggled);
      for (int r = 0; r < 2; r++)
      begin
        measure_run(cycles, toggled);
        assert (toggled && cycles == expected)
          else log_failure($sformatf("Error: tone run for note %0d = %h, expected %h",
                                     i, cycles, expected));
      end
    end
    report_test("tone_periods", errors_before);
  endtask

  task automatic check_tone_off();
    int errors_before;
    int accepted;
    errors_before = error_count;
    accepted = 0;
    tone_enable = 1'b0;
    audio_ready = 1'b1;
    repeat (8) next_cycle();
    repeat (200)
    begin
      next_cycle();
      assert (tone == 1'b0)
        else log_failure($sformatf("Error: tone = %h, expected 0", tone));
      if (audio_valid && audio_ready)
      begin
        accepted++;
        assert (audio_data == organ_pkg::SAMPLE_LOW)
          else log_failure($sformatf("Error: audio_data = %h, expected %h",
                                     audio_data, organ_pkg::SAMPLE_LOW));
      end
    end
    assert (accepted > 0)
      else log_failure("No audio sample was accepted while the tone was off");
    report_test("tone_off", errors_before);
  endtask

  task automatic check_display();
    int errors_before;
    int digit;
    display_pkg::seg_t expected;
    display_pkg::seg_t actual [4];
    errors_before = error_count;
    for (int i = 0; i < organ_pkg::NOTE_COUNT; i++)
    begin
      note_select = 3'(i);
      repeat (10) next_cycle();
      actual = '{hex0, hex1, hex2, hex3};
      for (int d = 0; d < 4; d++)
      begin
        // Decimal digit d of the note frequency in Hz
        digit = (organ_pkg::NOTE_HZ[i] / (10 ** d)) % 10;
        expected = display_pkg::SEG_DIGIT[4'(digit)];
        assert (actual[d] == expected)
          else log_failure($sformatf("Error: hex%0d = %h, expected %h",
                                     d, actual[d], expected));
      end
    end
    report_test("display", errors_before);
  endtask

  task automatic check_random_ready();
    int errors_before;
    int high_count;
    int low_count;
    bit held_valid;
    organ_pkg::sample_t held_data;
    errors_before = error_count;
    high_count = 0;
    low_count = 0;
    held_valid = 1'b0;
    held_data = '0;
    tone_enable = 1'b1;
    note_select = 3'd7;
    repeat (800)
    begin
      next_cycle();
      // A stall last cycle must leave the sample in place
      assert (!held_valid || (audio_valid && audio_data == held_data))
        else log_failure($sformatf("Error: stalled audio_data = %h, expected %h",
                                   audio_data, held_data));
      rng_state = next_random(rng_state);
      audio_ready = rng_state[4];
      if (audio_valid && audio_ready)
      begin
        if (audio_data == organ_pkg::SAMPLE_HIGH)
          high_count++;
        else if (audio_data == organ_pkg::SAMPLE_LOW)
          low_count++;
        else
          log_failure($sformatf("Error: audio_data = %h, expected 0f or 80", audio_data));
      end
      held_valid = audio_valid && !audio_ready;
      held_data = audio_data;
    end
    assert (high_count > 0 && low_count > 0)
      else log_failure("Accepted samples did not include both tone levels");
    audio_ready = 1'b1;
    report_test("random_ready", errors_before);
  endtask

  task automatic check_led_sweep();
    int errors_before;
    int exp_pos;
    int moves;
    int waited;
    bit going_down;
    display_pkg::led_t last_led;
    errors_before = error_count;
    apply_reset();
    exp_pos = 0;
    going_down = 1'b0;
    moves = 0;
    waited = 0;
    assert (led == display_pkg::led_t'(1))
      else log_failure($sformatf("Error: led = %h, expected 01", led));
    last_led = led;
    // Up to LED 7, back to LED 0, then the turn to LED 1
    while (moves < 15 && waited < RUN_LIMIT)
    begin
      next_cycle();
      waited++;
      if (led != last_led)
      begin
        if (exp_pos == display_pkg::LED_COUNT - 1)
          going_down = 1'b1;
        else if (exp_pos == 0)
          going_down = 1'b0;
        exp_pos = going_down ? exp_pos - 1 : exp_pos + 1;
        moves++;
        assert (led == (display_pkg::led_t'(1) << exp_pos))
          else log_failure($sformatf("Error: led = %h, expected %h",
                                     led, display_pkg::led_t'(1) << exp_pos));
        last_led = led;
      end
    end
    assert (moves == 15)
      else log_failure("The lit LED stopped moving before a full sweep");
    report_test("led_sweep", errors_before);
  endtask

  // ======================================================================
  // Run control
  // ======================================================================

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a test did not finish", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    clock = 1'b0;
    reset = 1'b1;
    note_select = '0;
    tone_enable = 1'b0;
    audio_ready = 1'b0;
    error_count = 0;
    rng_state = 32'd62835;
    apply_reset();
    check_tone_periods();
    check_tone_off();
    check_display();
    check_random_ready();
    check_led_sweep();
    $display("Tests run: 5, failed checks: %0d", error_count);
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/organ_tb_props.sv
`timescale 1ns/1ps
`default_nettype none

module organ_tb_props (
  input wire                     clock,
  input wire                     reset,
  input wire                     audio_valid,
  input wire                     audio_ready,
  input wire organ_pkg::sample_t audio_data,
  input wire display_pkg::led_t  led
);

  // Stalled sample stays put until the sink takes it
  stall_hold: assert property (@(posedge clock) disable iff (reset)
    (audio_valid && !audio_ready) |=> (audio_valid && $stable(audio_data)))
    else $error("audio sample changed or vanished while stalled");

  led_one_hot: assert property (@(posedge clock) disable iff (reset)
    $onehot(led))
    else $error("led is not one-hot");

  // Only the two tone levels ever leave the stream
  sample_legal: assert property (@(posedge clock) disable iff (reset)
    audio_valid |-> (audio_data == organ_pkg::SAMPLE_HIGH ||
                     audio_data == organ_pkg::SAMPLE_LOW))
    else $error("audio_data holds a value that is not a tone level");

endmodule

`default_nettype wire
